// ==== source/lsq_config.svh ====
`ifndef LSQ_CONFIG_SVH
`define LSQ_CONFIG_SVH

// Stores dispatched and retired per cycle.
`define SQ_WIDTH      2
`define SQ_WIDTH_BITS 2

// Ring geometry.
`define SQ_SIZE       8
`define SQ_IDX_BITS   3
`define SQ_CNT_BITS   4   // Holds 0 through SQ_SIZE.

// Memory word, four bytes per word.
`define ADDR_BITS     32
`define DATA_BITS     32

`endif

// ==== source/lsq_pkg.sv ====
`include "lsq_config.svh"

package lsq_pkg;

    // Position of an entry in the ring.
    typedef logic [`SQ_IDX_BITS-1:0] sq_idx_t;

    // Occupancy, wide enough for a full ring.
    typedef logic [`SQ_CNT_BITS-1:0] sq_cnt_t;

    // Drain to the data cache.
    // DRAIN_WAIT holds one store on the cache port until it is accepted.
    typedef enum logic {
        DRAIN_IDLE,
        DRAIN_WAIT
    } drain_state_t;

endpackage

// ==== source/store_queue.sv ====
`timescale 1ns/1ps

`include "lsq_config.svh"

module store_queue (
    input  logic                               clock,
    input  logic                               reset,
    input  logic [`SQ_WIDTH-1:0]               stores_dispatched,
    input  logic                               fill_valid,
    input  lsq_pkg::sq_idx_t                   fill_idx,
    input  logic [`ADDR_BITS-1:0]              fill_addr,
    input  logic [`DATA_BITS-1:0]              fill_data,
    input  logic [`DATA_BITS/8-1:0]            fill_mask,
    input  logic [`SQ_WIDTH_BITS-1:0]          num_sq_retiring,
    input  logic                               sq_restore_valid,
    input  lsq_pkg::sq_idx_t                   sq_tail_restore,
    input  logic                               pop,
    output logic [`SQ_WIDTH_BITS-1:0]          sq_spots,
    output lsq_pkg::sq_idx_t                   sq_tail,
    output lsq_pkg::sq_idx_t                   sq_head,
    output logic [`SQ_SIZE-1:0]                entry_filled,
    output logic [`SQ_SIZE*`ADDR_BITS-1:0]     entry_addr,
    output logic [`SQ_SIZE*`DATA_BITS-1:0]     entry_data,
    output logic [`SQ_SIZE*(`DATA_BITS/8)-1:0] entry_mask,
    output logic                               head_committed,
    output logic [`ADDR_BITS-1:0]              head_addr,
    output logic [`DATA_BITS-1:0]              head_data,
    output logic [`DATA_BITS/8-1:0]            head_mask
);
    import lsq_pkg::*;

    localparam int BYTES = `DATA_BITS / 8;

    // Entry payload, written by the store unit.
    logic [`ADDR_BITS-1:0] addr_q [`SQ_SIZE];
    logic [`DATA_BITS-1:0] data_q [`SQ_SIZE];
    logic [BYTES-1:0]      mask_q [`SQ_SIZE];

    // Per-entry status.
    logic [`SQ_SIZE-1:0] filled_q;
    logic [`SQ_SIZE-1:0] committed_q;

    sq_idx_t head;
    sq_idx_t next_head;
    sq_idx_t commit_ptr;   // Oldest uncommitted entry.
    sq_idx_t next_commit;
    sq_idx_t tail;
    sq_idx_t next_tail;
    sq_cnt_t count;
    sq_cnt_t next_count;
    sq_cnt_t free_entries;

    logic [`SQ_WIDTH_BITS-1:0] num_alloc;
    logic                      committed_left;

    function automatic sq_idx_t wrap_add(sq_idx_t base, int unsigned offset);
        int unsigned sum;
        sum = (base + offset) % `SQ_SIZE;
        return sq_idx_t'(sum);
    endfunction

    // Number of stores dispatched this cycle.
    always_comb begin
        num_alloc = '0;
        for (int i = 0; i < `SQ_WIDTH; i++) begin
            num_alloc = num_alloc + stores_dispatched[i];
        end
    end

    always_comb begin
        next_head   = pop ? wrap_add(head, 1) : head;
        next_commit = wrap_add(commit_ptr, num_sq_retiring);

        // Committed stores still in the ring once this cycle is done.
        if (num_sq_retiring != '0) begin
            committed_left = 1'b1;
        end else if (pop) begin
            committed_left = committed_q[wrap_add(head, 1)];
        end else begin
            committed_left = committed_q[head];
        end

        if (sq_restore_valid) begin
            next_tail = sq_tail_restore;
            // Tail on the head is a full ring only if committed stores remain.
            if (sq_tail_restore == next_head) begin
                next_count = committed_left ? sq_cnt_t'(`SQ_SIZE) : '0;
            end else begin
                next_count = sq_cnt_t'((sq_tail_restore + `SQ_SIZE - next_head) % `SQ_SIZE);
            end
        end else begin
            next_tail  = wrap_add(tail, num_alloc);
            next_count = count + num_alloc - pop;
        end
    end

    // Free entries, capped at the dispatch width.
    assign free_entries = sq_cnt_t'(`SQ_SIZE) - count;
    assign sq_spots = (free_entries < `SQ_WIDTH) ? free_entries[`SQ_WIDTH_BITS-1:0]
                                                 : `SQ_WIDTH_BITS'(`SQ_WIDTH);

    always_ff @(posedge clock) begin
        if (reset) begin
            head        <= '0;
            commit_ptr  <= '0;
            tail        <= '0;
            count       <= '0;
            filled_q    <= '0;
            committed_q <= '0;
        end else begin
            head       <= next_head;
            commit_ptr <= next_commit;
            tail       <= next_tail;
            count      <= next_count;

            if (pop) begin
                committed_q[head] <= 1'b0;   // Head leaves the ring.
            end

            for (int i = 0; i < `SQ_WIDTH; i++) begin
                if (i < num_sq_retiring) begin
                    committed_q[wrap_add(commit_ptr, i)] <= 1'b1;
                end
            end

            // New stores start empty. A restore drops this cycle's dispatch.
            if (!sq_restore_valid) begin
                for (int i = 0; i < `SQ_WIDTH; i++) begin
                    if (i < num_alloc) begin
                        filled_q[wrap_add(tail, i)]    <= 1'b0;
                        committed_q[wrap_add(tail, i)] <= 1'b0;
                    end
                end
            end

            if (fill_valid) begin
                filled_q[fill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (fill_valid) begin
            addr_q[fill_idx] <= fill_addr;
            data_q[fill_idx] <= fill_data;
            mask_q[fill_idx] <= fill_mask;
        end
    end

    // Flattened view for the forwarding search.
    always_comb begin
        for (int i = 0; i < `SQ_SIZE; i++) begin
            entry_addr[i*`ADDR_BITS +: `ADDR_BITS] = addr_q[i];
            entry_data[i*`DATA_BITS +: `DATA_BITS] = data_q[i];
            entry_mask[i*BYTES +: BYTES]           = mask_q[i];
        end
    end

    assign entry_filled = filled_q;

    assign sq_head = head;
    assign sq_tail = tail;

    // Oldest store, offered to the drain once committed.
    assign head_committed = committed_q[head];
    assign head_addr      = addr_q[head];
    assign head_data      = data_q[head];
    assign head_mask      = mask_q[head];

endmodule

// ==== source/store_forward.sv ====
`timescale 1ns/1ps

`include "lsq_config.svh"

module store_forward (
    input  lsq_pkg::sq_idx_t                   sq_head,
    input  lsq_pkg::sq_idx_t                   load_sq_tail,
    input  logic [`ADDR_BITS-1:0]              load_addr,
    input  logic [`SQ_SIZE-1:0]                entry_filled,
    input  logic [`SQ_SIZE*`ADDR_BITS-1:0]     entry_addr,
    input  logic [`SQ_SIZE*`DATA_BITS-1:0]     entry_data,
    input  logic [`SQ_SIZE*(`DATA_BITS/8)-1:0] entry_mask,
    output logic [`DATA_BITS-1:0]              sq_load_data,
    output logic [`DATA_BITS/8-1:0]            sq_data_mask
);
    import lsq_pkg::*;

    localparam int BYTES       = `DATA_BITS / 8;
    localparam int OFFSET_BITS = $clog2(BYTES);

    sq_idx_t               span;   // Stores older than the load.
    sq_idx_t               idx;
    logic [`ADDR_BITS-1:0] st_addr;
    logic [`DATA_BITS-1:0] st_data;
    logic [BYTES-1:0]      st_mask;
    logic                  word_hit;

    // Oldest to youngest, so younger bytes overwrite older ones.
    // A tail snapshot equal to the head gives an empty range.
    always_comb begin
        span         = sq_idx_t'((load_sq_tail + `SQ_SIZE - sq_head) % `SQ_SIZE);
        sq_load_data = '0;
        sq_data_mask = '0;
        idx          = sq_head;
        st_addr      = '0;
        st_data      = '0;
        st_mask      = '0;
        word_hit     = 1'b0;

        for (int i = 0; i < `SQ_SIZE; i++) begin
            idx     = sq_idx_t'((sq_head + i) % `SQ_SIZE);
            st_addr = entry_addr[idx*`ADDR_BITS +: `ADDR_BITS];
            st_data = entry_data[idx*`DATA_BITS +: `DATA_BITS];
            st_mask = entry_mask[idx*BYTES +: BYTES];

            // Same word, byte offset ignored.
            word_hit = st_addr[`ADDR_BITS-1:OFFSET_BITS] == load_addr[`ADDR_BITS-1:OFFSET_BITS];

            // Unfilled stores have no known address and are skipped.
            if ((i < span) && entry_filled[idx] && word_hit) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (st_mask[b]) begin
                        sq_load_data[b*8 +: 8] = st_data[b*8 +: 8];
                        sq_data_mask[b]        = 1'b1;
                    end
                end
            end
        end
    end

endmodule

// ==== source/store_drain.sv ====
`timescale 1ns/1ps

`include "lsq_config.svh"

module store_drain (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    head_committed,
    input  logic [`ADDR_BITS-1:0]   head_addr,
    input  logic [`DATA_BITS-1:0]   head_data,
    input  logic [`DATA_BITS/8-1:0] head_mask,
    input  logic                    cache_store_accepted,
    output logic                    pop,
    output logic                    cache_store_valid,
    output logic [`ADDR_BITS-1:0]   cache_store_addr,
    output logic [`DATA_BITS-1:0]   cache_store_data,
    output logic [`DATA_BITS/8-1:0] cache_store_mask
);
    import lsq_pkg::*;

    drain_state_t state;
    drain_state_t next_state;
    logic         capture;

    always_comb begin
        next_state = state;
        capture    = 1'b0;
        pop        = 1'b0;
        case (state)
            DRAIN_IDLE: begin
                if (head_committed) begin
                    capture    = 1'b1;
                    next_state = DRAIN_WAIT;
                end
            end
            DRAIN_WAIT: begin
                // Head advances on the same edge that ends the transfer.
                if (cache_store_accepted) begin
                    pop        = 1'b1;
                    next_state = DRAIN_IDLE;
                end
            end
            default: next_state = DRAIN_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state             <= DRAIN_IDLE;
            cache_store_valid <= 1'b0;
        end else begin
            state <= next_state;
            if (capture) begin
                cache_store_valid <= 1'b1;
            end else if (pop) begin
                cache_store_valid <= 1'b0;
            end
        end
    end

    // Registered copy keeps the cache port steady while the queue moves.
    always_ff @(posedge clock) begin
        if (capture) begin
            cache_store_addr <= head_addr;
            cache_store_data <= head_data;
            cache_store_mask <= head_mask;
        end
    end

endmodule

// ==== source/store_subsystem.sv ====
`timescale 1ns/1ps

`include "lsq_config.svh"

module store_subsystem (
    input  logic                      clock,
    input  logic                      reset,
    input  logic [`SQ_WIDTH-1:0]      stores_dispatched,
    output logic [`SQ_WIDTH_BITS-1:0] sq_spots,
    output lsq_pkg::sq_idx_t          sq_tail,
    input  logic                      fill_valid,
    input  lsq_pkg::sq_idx_t          fill_idx,
    input  logic [`ADDR_BITS-1:0]     fill_addr,
    input  logic [`DATA_BITS-1:0]     fill_data,
    input  logic [`DATA_BITS/8-1:0]   fill_mask,
    input  lsq_pkg::sq_idx_t          load_sq_tail,
    input  logic [`ADDR_BITS-1:0]     load_addr,
    output logic [`DATA_BITS-1:0]     sq_load_data,
    output logic [`DATA_BITS/8-1:0]   sq_data_mask,
    input  logic [`SQ_WIDTH_BITS-1:0] num_sq_retiring,
    input  logic                      sq_restore_valid,
    input  lsq_pkg::sq_idx_t          sq_tail_restore,
    input  logic                      cache_store_accepted,
    output logic                      cache_store_valid,
    output logic [`ADDR_BITS-1:0]     cache_store_addr,
    output logic [`DATA_BITS-1:0]     cache_store_data,
    output logic [`DATA_BITS/8-1:0]   cache_store_mask
);
    import lsq_pkg::*;

    sq_idx_t                            sq_head;
    logic [`SQ_SIZE-1:0]                entry_filled;
    logic [`SQ_SIZE*`ADDR_BITS-1:0]     entry_addr;
    logic [`SQ_SIZE*`DATA_BITS-1:0]     entry_data;
    logic [`SQ_SIZE*(`DATA_BITS/8)-1:0] entry_mask;
    logic                               head_committed;
    logic [`ADDR_BITS-1:0]              head_addr;
    logic [`DATA_BITS-1:0]              head_data;
    logic [`DATA_BITS/8-1:0]            head_mask;
    logic                               pop;

    store_queue u_store_queue (
        .clock             (clock),
        .reset             (reset),
        .stores_dispatched (stores_dispatched),
        .fill_valid        (fill_valid),
        .fill_idx          (fill_idx),
        .fill_addr         (fill_addr),
        .fill_data         (fill_data),
        .fill_mask         (fill_mask),
        .num_sq_retiring   (num_sq_retiring),
        .sq_restore_valid  (sq_restore_valid),
        .sq_tail_restore   (sq_tail_restore),
        .pop               (pop),
        .sq_spots          (sq_spots),
        .sq_tail           (sq_tail),
        .sq_head           (sq_head),
        .entry_filled      (entry_filled),
        .entry_addr        (entry_addr),
        .entry_data        (entry_data),
        .entry_mask        (entry_mask),
        .head_committed    (head_committed),
        .head_addr         (head_addr),
        .head_data         (head_data),
        .head_mask         (head_mask)
    );

    // Zero-latency load search.
    store_forward u_store_forward (
        .sq_head      (sq_head),
        .load_sq_tail (load_sq_tail),
        .load_addr    (load_addr),
        .entry_filled (entry_filled),
        .entry_addr   (entry_addr),
        .entry_data   (entry_data),
        .entry_mask   (entry_mask),
        .sq_load_data (sq_load_data),
        .sq_data_mask (sq_data_mask)
    );

    store_drain u_store_drain (
        .clock                (clock),
        .reset                (reset),
        .head_committed       (head_committed),
        .head_addr            (head_addr),
        .head_data            (head_data),
        .head_mask            (head_mask),
        .cache_store_accepted (cache_store_accepted),
        .pop                  (pop),
        .cache_store_valid    (cache_store_valid),
        .cache_store_addr     (cache_store_addr),
        .cache_store_data     (cache_store_data),
        .cache_store_mask     (cache_store_mask)
    );

endmodule

// ==== testbench/store_subsystem_tb.sv ====
`timescale 1ns/1ps

`include "lsq_config.svh"

module store_subsystem_tb;
    import lsq_pkg::*;

    localparam int          NUM_CYCLES     = 400;
    localparam int          TIMEOUT_CYCLES = 20 * NUM_CYCLES;
    localparam int          BYTES          = `DATA_BITS / 8;
    localparam int          OFFSET         = $clog2(BYTES);
    localparam logic [31:0] ADDR_BASE      = 32'h0000_1000;

    logic                      clock = 1'b0;
    logic                      reset;
    logic [`SQ_WIDTH-1:0]      stores_dispatched;
    logic [`SQ_WIDTH_BITS-1:0] sq_spots;
    sq_idx_t                   sq_tail;
    logic                      fill_valid;
    sq_idx_t                   fill_idx;
    logic [`ADDR_BITS-1:0]     fill_addr;
    logic [`DATA_BITS-1:0]     fill_data;
    logic [BYTES-1:0]          fill_mask;
    sq_idx_t                   load_sq_tail;
    logic [`ADDR_BITS-1:0]     load_addr;
    logic [`DATA_BITS-1:0]     sq_load_data;
    logic [BYTES-1:0]          sq_data_mask;
    logic [`SQ_WIDTH_BITS-1:0] num_sq_retiring;
    logic                      sq_restore_valid;
    sq_idx_t                   sq_tail_restore;
    logic                      cache_store_accepted;
    logic                      cache_store_valid;
    logic [`ADDR_BITS-1:0]     cache_store_addr;
    logic [`DATA_BITS-1:0]     cache_store_data;
    logic [BYTES-1:0]          cache_store_mask;

    // Reference ring. Tail is head plus count.
    logic [`ADDR_BITS-1:0] m_addr [`SQ_SIZE];
    logic [`DATA_BITS-1:0] m_data [`SQ_SIZE];
    logic [BYTES-1:0]      m_mask [`SQ_SIZE];
    bit                    m_filled [`SQ_SIZE];
    bit                    m_committed [`SQ_SIZE];
    int unsigned           m_head, m_count, m_ncommit;

    int          errors = 0, retired = 0, drained = 0, cycle_count = 0;
    bit          saw_full = 1'b0;
    bit          in_transfer = 1'b0;   // Cache side holds an offered store.
    int unsigned wait_left;
    logic [`ADDR_BITS-1:0] held_addr;
    logic [`DATA_BITS-1:0] held_data;
    logic [BYTES-1:0]      held_mask;

    store_subsystem u_store_subsystem (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, queue did not drain", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        errors++;
        $display("** Error [%s] expected %0h, actual %0h", test, expected, actual);
    endtask

    task automatic log_failure(input string what);
        errors++;
        $display("Failure: %s", what);
    endtask

    // Byte merge over the stores older than the load, taken oldest first.
    task automatic forward_expected(input int unsigned span, input logic [31:0] addr,
                                    output logic [31:0] data, output logic [BYTES-1:0] mask);
        int unsigned idx;
        data = '0;
        mask = '0;
        for (int i = 0; i < span; i++) begin
            idx = (m_head + i) % `SQ_SIZE;
            if (m_filled[idx] && (m_addr[idx] >> OFFSET) == (addr >> OFFSET)) begin
                for (int b = 0; b < BYTES; b++) begin
                    if (m_mask[idx][b]) begin
                        data[b*8 +: 8] = m_data[idx][b*8 +: 8];
                        mask[b]        = 1'b1;
                    end
                end
            end
        end
    endtask

    // One clock of stimulus, checks and model update.
    task automatic run_cycle(input bit random_ops);
        int unsigned spots, uncommitted, commit_idx, tail_idx, idx, start;
        int unsigned n_disp, n_ret, avail, restore_off, load_off, fill_pick;
        int unsigned open_list [$];
        bit do_restore, do_fill, do_pop;
        logic [`DATA_BITS-1:0] exp_data;
        logic [BYTES-1:0]      exp_mask;

        @(negedge clock);
        spots       = (`SQ_SIZE - m_count < `SQ_WIDTH) ? `SQ_SIZE - m_count : `SQ_WIDTH;
        uncommitted = m_count - m_ncommit;
        commit_idx  = (m_head + m_ncommit) % `SQ_SIZE;
        tail_idx    = (m_head + m_count) % `SQ_SIZE;
        if (sq_spots !== spots[`SQ_WIDTH_BITS-1:0]) report_mismatch("sq_spots", spots, sq_spots);
        if (sq_tail !== sq_idx_t'(tail_idx)) report_mismatch("sq_tail", tail_idx, sq_tail);
        if (sq_spots == 0) saw_full = 1'b1;

        // Cache side. A new offer must be the oldest committed store.
        do_pop = 1'b0;
        if (cache_store_valid) begin
            if (!in_transfer) begin
                in_transfer = 1'b1;
                held_addr   = cache_store_addr;
                held_data   = cache_store_data;
                held_mask   = cache_store_mask;
                wait_left   = $urandom_range(5, 0);
                if (!m_committed[m_head]) begin
                    log_failure("cache store offered with no committed store in the queue");
                end else begin
                    if (held_addr !== m_addr[m_head])
                        report_mismatch("drain addr", m_addr[m_head], held_addr);
                    if (held_data !== m_data[m_head])
                        report_mismatch("drain data", m_data[m_head], held_data);
                    if (held_mask !== m_mask[m_head])
                        report_mismatch("drain mask", m_mask[m_head], held_mask);
                end
            end
            if (cache_store_addr !== held_addr)
                report_mismatch("drain addr held", held_addr, cache_store_addr);
            if (cache_store_data !== held_data)
                report_mismatch("drain data held", held_data, cache_store_data);
            if (cache_store_mask !== held_mask)
                report_mismatch("drain mask held", held_mask, cache_store_mask);
            if (wait_left == 0) begin
                do_pop      = 1'b1;
                in_transfer = 1'b0;
                drained++;
            end else begin
                wait_left--;
            end
        end
        cache_store_accepted = do_pop;

        n_disp      = 0;
        n_ret       = 0;
        do_fill     = 1'b0;
        fill_pick   = 0;
        restore_off = 0;
        do_restore  = random_ops && (uncommitted > 0) && ($urandom_range(15, 0) == 0);
        if (do_restore) begin
            restore_off = $urandom_range(uncommitted - 1, 0);   // Drops at least one store.
        end else begin
            if (random_ops) n_disp = $urandom_range(spots, 0);
            avail = 0;
            while (avail < uncommitted && avail < `SQ_WIDTH &&
                   m_filled[(commit_idx + avail) % `SQ_SIZE]) begin
                avail++;
            end
            n_ret = random_ops ? $urandom_range(avail, 0) : avail;
            for (int i = 0; i < uncommitted; i++) begin
                idx = (commit_idx + i) % `SQ_SIZE;
                if (!m_filled[idx]) open_list.push_back(idx);
            end
            if (open_list.size() > 0 && (!random_ops || $urandom_range(3, 0) != 0)) begin
                do_fill   = 1'b1;
                fill_pick = open_list[$urandom_range(open_list.size() - 1, 0)];
            end
        end

        stores_dispatched = '0;
        start             = $urandom_range(`SQ_WIDTH - 1, 0);
        for (int i = 0; i < n_disp; i++)
            stores_dispatched[(start + i) % `SQ_WIDTH] = 1'b1;
        fill_valid       = do_fill;
        fill_idx         = sq_idx_t'(fill_pick);
        fill_addr        = ADDR_BASE + 4 * $urandom_range(3, 0) + $urandom_range(3, 0);
        fill_data        = $urandom();
        fill_mask        = $urandom_range(15, 0);
        num_sq_retiring  = n_ret[`SQ_WIDTH_BITS-1:0];
        sq_restore_valid = do_restore;
        sq_tail_restore  = sq_idx_t'((commit_idx + restore_off) % `SQ_SIZE);
        load_off         = $urandom_range((m_count < `SQ_SIZE) ? m_count : `SQ_SIZE - 1, 0);
        load_sq_tail     = sq_idx_t'((m_head + load_off) % `SQ_SIZE);
        load_addr        = ADDR_BASE + 4 * $urandom_range(3, 0) + $urandom_range(3, 0);

        #1;
        forward_expected(load_off, load_addr, exp_data, exp_mask);
        if (sq_load_data !== exp_data) report_mismatch("forward data", exp_data, sq_load_data);
        if (sq_data_mask !== exp_mask) report_mismatch("forward mask", exp_mask, sq_data_mask);

        // Model takes the effect of the coming rising edge.
        if (do_fill) begin
            m_filled[fill_pick] = 1'b1;
            m_addr[fill_pick]   = fill_addr;
            m_data[fill_pick]   = fill_data;
            m_mask[fill_pick]   = fill_mask;
        end
        for (int i = 0; i < n_ret; i++)
            m_committed[(commit_idx + i) % `SQ_SIZE] = 1'b1;
        m_ncommit += n_ret;
        retired   += n_ret;
        for (int i = 0; i < n_disp; i++) begin
            idx              = (tail_idx + i) % `SQ_SIZE;
            m_filled[idx]    = 1'b0;
            m_committed[idx] = 1'b0;
        end
        m_count += n_disp;
        if (do_pop && m_ncommit > 0) begin
            m_committed[m_head] = 1'b0;
            m_head              = (m_head + 1) % `SQ_SIZE;
            m_count--;
            m_ncommit--;
        end
        if (do_restore) m_count = m_ncommit + restore_off;
    endtask

    initial begin
        void'($urandom(39020));
        reset                = 1'b1;
        stores_dispatched    = '0;
        fill_valid           = 1'b0;
        fill_idx             = '0;
        fill_addr            = '0;
        fill_data            = '0;
        fill_mask            = '0;
        load_sq_tail         = '0;
        load_addr            = '0;
        num_sq_retiring      = '0;
        sq_restore_valid     = 1'b0;
        sq_tail_restore      = '0;
        cache_store_accepted = 1'b0;
        m_head               = 0;
        m_count              = 0;
        m_ncommit            = 0;
        for (int i = 0; i < `SQ_SIZE; i++) begin
            m_filled[i]    = 1'b0;
            m_committed[i] = 1'b0;
        end

        repeat (10) @(posedge clock);
        @(negedge clock);
        if (sq_spots !== `SQ_WIDTH) report_mismatch("reset sq_spots", `SQ_WIDTH, sq_spots);
        if (sq_tail !== '0) report_mismatch("reset sq_tail", 0, sq_tail);
        if (cache_store_valid !== 1'b0) report_mismatch("reset valid", 0, cache_store_valid);
        reset = 1'b0;

        repeat (NUM_CYCLES) run_cycle(1'b1);

        // Fill, retire and drain whatever is left.
        while (m_count != 0 || in_transfer) run_cycle(1'b0);
        repeat (6) run_cycle(1'b0);

        if (cache_store_valid !== 1'b0) log_failure("cache store offered after the queue emptied");
        if (drained != retired) report_mismatch("drained count", retired, drained);
        if (!saw_full) log_failure("queue never reported zero free spots");

        $display("Errors: %0d, stores retired: %0d, stores drained: %0d",
                 errors, retired, drained);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+source
source/lsq_pkg.sv
source/store_queue.sv
source/store_forward.sv
source/store_drain.sv
source/store_subsystem.sv
testbench/store_subsystem_tb.sv

// ==== Bender.yml ====
package:
  name: store_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/lsq_pkg.sv
      - source/store_queue.sv
      - source/store_forward.sv
      - source/store_drain.sv
      - source/store_subsystem.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/store_subsystem_tb.sv
